// ==== Makefile ====
# Verilator build and run for the digital clock testbench

TOP       ?= digital_clock_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
PASS_MSG  := All checks passed

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := dv/clock_checks.svh
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/clock_checks.svh ====
`ifndef CLOCK_CHECKS_SVH
`define CLOCK_CHECKS_SVH

int unsigned value_errors = 0;
int unsigned other_errors = 0;

// exactly one digit enable low at any time
com_one_low: assert property (@(negedge clk) disable iff (rst) $onehot(~o_fnd_com))
    else begin
        other_errors++;
        $display("at %0t the digit enables o_fnd_com=%b do not have exactly one low bit",
                 $time, o_fnd_com);
    end

task automatic expect_eq(input string name, input int got, input int expected);
    assert (got == expected) else begin
        value_errors++;
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, expected);
    end
endtask

task automatic expect_true(input bit cond, input string what);
    assert (cond) else begin
        other_errors++;
        $display("at %0t %s", $time, what);
    end
endtask

// per-phase segment rules
task automatic check_segments(input int phase, input clock_pkg::seg_t seg);
    case (phase)
        4, 5, 7: begin
            assert (seg == clock_pkg::SEG_BLANK) else begin
                value_errors++;
                $display("[FAIL] %0t o_fnd_data in phase %0d got %h expected %h",
                         $time, phase, seg, clock_pkg::SEG_BLANK);
            end
        end
        6: begin
            assert (seg == clock_pkg::SEG_DP || seg == clock_pkg::SEG_BLANK) else begin
                other_errors++;
                $display("at %0t phase 6 shows %h, neither a decimal point nor blank",
                         $time, seg);
            end
        end
        default: begin
            assert (seg_digit(seg) < 10) else begin
                other_errors++;
                $display("at %0t phase %0d shows %h, which is no digit code",
                         $time, phase, seg);
            end
        end
    endcase
endtask

// only called on frames where the shown second:centisecond value is frozen
task automatic check_frame_dp();
    int cs_shown;
    cs_shown = frame[1] * 10 + frame[0];
    expect_eq("decimal point", int'(frame_dp),
              (cs_shown >= int'(clock_pkg::DP_FROM_CS)) ? 1 : 0);
endtask

`endif

// ==== dv/digital_clock_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module digital_clock_tb;

    localparam int CS_TICKS   = 4;
    localparam int SCAN_TICKS = 2;
    localparam int MAX_CYCLES = 20_000;    // sequence needs about 7000
    localparam int BTN_UP     = 0;
    localparam int BTN_DOWN   = 1;
    localparam int BTN_RUN    = 2;
    localparam int BTN_CLEAR  = 3;

    logic clk;
    logic rst;
    logic i_btn_up;
    logic i_btn_down;
    logic i_btn_run_stop;
    logic i_btn_clear;
    logic i_sel_stopwatch;
    logic i_show_hour_min;
    logic i_set_sec;
    logic i_set_min;
    logic i_set_hour;
    clock_pkg::seg_t o_fnd_data;
    logic [3:0]      o_fnd_com;
    logic            o_cuckoo;

    integer seed = 32'h7738fd99;
    int     frame_count = 0;
    int     cur_digits [4];
    int     frame [4];         // ones lo, tens lo, ones hi, tens hi
    logic   cur_dp;
    logic   frame_dp;
    logic   dp_check_en = 1'b0;
    logic   half;
    int     prev_idx;
    int     prev_phase;
    int     exp_hour = 12;
    int     exp_min = 0;

    digital_clock_top #(.CS_TICKS(CS_TICKS), .SCAN_TICKS(SCAN_TICKS)) DUT (
        .clk             (clk),
        .rst             (rst),
        .i_btn_up        (i_btn_up),
        .i_btn_down      (i_btn_down),
        .i_btn_run_stop  (i_btn_run_stop),
        .i_btn_clear     (i_btn_clear),
        .i_sel_stopwatch (i_sel_stopwatch),
        .i_show_hour_min (i_show_hour_min),
        .i_set_sec       (i_set_sec),
        .i_set_min       (i_set_min),
        .i_set_hour      (i_set_hour),
        .o_fnd_data      (o_fnd_data),
        .o_fnd_com       (o_fnd_com),
        .o_cuckoo        (o_cuckoo)
    );

    function automatic int seg_digit(input clock_pkg::seg_t seg);
        for (int d = 0; d < 10; d++) begin
            if (clock_pkg::SEG_DIGITS[d] == seg) begin
                return d;
            end
        end
        return 15;
    endfunction

    function automatic int com_index(input logic [3:0] com);
        case (com)
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return 0;
        endcase
    endfunction

    function automatic int cuckoo_rule(input int hour, input int minute);
        return (minute == 0 && hour >= int'(clock_pkg::CUCKOO_FROM_HOUR)) ? 1 : 0;
    endfunction

    `include "clock_checks.svh"

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, test sequence did not finish", cycles);
        $display("Checks failed");
        $finish;
    end

    // com only gives phase[1:0], the upper half is tracked from the wrap 3 -> 0
    always @(negedge clk) begin : display_decoder
        int idx;
        int phase;
        if (rst) begin
            half = 1'b1;
            prev_idx = 3;
            prev_phase = 7;
        end else begin
            idx = com_index(o_fnd_com);
            if (idx == 0 && prev_idx == 3) begin
                half = ~half;
            end
            phase = (half ? 4 : 0) + idx;
            check_segments(phase, o_fnd_data);
            if (phase < 4) begin
                cur_digits[phase] = seg_digit(o_fnd_data);
            end else if (phase == 6) begin
                cur_dp = (o_fnd_data == clock_pkg::SEG_DP);
            end else if (phase == 7 && prev_phase == 6) begin
                frame = cur_digits;
                frame_dp = cur_dp;
                frame_count++;
                if (dp_check_en) begin
                    check_frame_dp();
                end
            end
            prev_idx = idx;
            prev_phase = phase;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // n frames that start after the call
    task automatic next_frames(input int n);
        int target;
        target = frame_count + n + 1;
        wait (frame_count >= target);
        wait_cycles(1);
    endtask

    task automatic read_frame(output int hi, output int lo);
        next_frames(1);
        hi = frame[3] * 10 + frame[2];
        lo = frame[1] * 10 + frame[0];
    endtask

    task automatic drive_button(input int which, input logic level);
        case (which)
            BTN_UP:   i_btn_up = level;
            BTN_DOWN: i_btn_down = level;
            BTN_RUN:  i_btn_run_stop = level;
            default:  i_btn_clear = level;
        endcase
    endtask

    task automatic press(input int which);
        drive_button(which, 1'b1);
        wait_cycles(1);
        drive_button(which, 1'b0);
        wait_cycles(2);
    endtask

    task automatic check_hour_min();
        int hi;
        int lo;
        read_frame(hi, lo);
        expect_eq("watch hour", hi, exp_hour);
        expect_eq("watch minute", lo, exp_min);
        expect_eq("o_cuckoo", int'(o_cuckoo), cuckoo_rule(exp_hour, exp_min));
    endtask

    task automatic set_field(input bit hour_field, input int presses, input bit up);
        i_set_min = !hour_field;
        i_set_hour = hour_field;
        repeat (presses) begin
            press(up ? BTN_UP : BTN_DOWN);
            if (hour_field) begin
                exp_hour = up ? (exp_hour + 1) % 24 : (exp_hour + 23) % 24;
            end else if (up) begin
                if (exp_min == 59) begin
                    exp_hour = (exp_hour + 1) % 24;    // carry out of the minute
                end
                exp_min = (exp_min + 1) % 60;
            end else begin
                exp_min = (exp_min + 59) % 60;
            end
        end
        i_set_min = 1'b0;
        i_set_hour = 1'b0;
        check_hour_min();
    endtask

    initial begin : stimulus
        int hi;
        int lo;
        int hi2;
        int lo2;
        int k;
        int v;
        int prev_v;
        int first_v;
        rst = 1'b1;
        i_btn_up = 1'b0;
        i_btn_down = 1'b0;
        i_btn_run_stop = 1'b0;
        i_btn_clear = 1'b0;
        i_sel_stopwatch = 1'b0;
        i_show_hour_min = 1'b1;
        i_set_sec = 1'b0;
        i_set_min = 1'b0;
        i_set_hour = 1'b0;
        wait_cycles(8);
        rst = 1'b0;

        check_hour_min();
        k = 50 + int'($unsigned($random(seed)) % 20);
        set_field(1'b0, k, 1'b1);
        set_field(1'b1, exp_hour, 1'b0);    // down to hour 0
        set_field(1'b1, 1, 1'b0);           // 0 wraps to 23
        set_field(1'b0, exp_min, 1'b0);
        set_field(1'b1, 17, 1'b0);
        set_field(1'b1, 1, 1'b1);

        // watch runs, second:centisecond
        i_show_hour_min = 1'b0;
        read_frame(hi, lo);
        first_v = hi * 100 + lo;
        prev_v = first_v;
        repeat (40) begin
            read_frame(hi, lo);
            v = hi * 100 + lo;
            expect_true(v >= prev_v || (prev_v > 5900 && v < 100), "watch time went backwards");
            prev_v = v;
        end
        expect_true(v != first_v, "watch did not advance");

        press(BTN_RUN);    // ignored, watch shown
        i_sel_stopwatch = 1'b1;
        repeat (3) begin
            read_frame(hi, lo);
            expect_eq("stopwatch sec", hi, 0);
            expect_eq("stopwatch cs", lo, 0);
        end

        // run and freeze at scattered centisecond values
        repeat (10) begin
            dp_check_en = 1'b0;
            press(BTN_RUN);
            read_frame(hi, lo);
            read_frame(hi2, lo2);
            expect_true(hi * 100 + lo != hi2 * 100 + lo2, "stopwatch did not advance while running");
            wait_cycles(int'($unsigned($random(seed)) % 400));
            press(BTN_RUN);
            next_frames(1);
            dp_check_en = 1'b1;
            read_frame(hi, lo);
            read_frame(hi2, lo2);
            expect_eq("stopped sec", hi2, hi);
            expect_eq("stopped cs", lo2, lo);
        end
        dp_check_en = 1'b0;

        i_show_hour_min = 1'b1;
        read_frame(hi2, lo2);
        expect_eq("stopwatch hour", hi2, 0);
        expect_eq("stopwatch minute", lo2, 0);
        i_show_hour_min = 1'b0;
        read_frame(hi2, lo2);
        expect_eq("stopwatch sec after toggle", hi2, hi);
        expect_eq("stopwatch cs after toggle", lo2, lo);

        press(BTN_CLEAR);
        press(BTN_RUN);    // no effect while clearing
        repeat (3) begin
            read_frame(hi, lo);
            expect_eq("cleared sec", hi, 0);
            expect_eq("cleared cs", lo, 0);
        end
        press(BTN_CLEAR);
        read_frame(hi, lo);
        expect_eq("stopped sec", hi, 0);
        expect_eq("stopped cs", lo, 0);
        press(BTN_RUN);
        read_frame(hi, lo);
        read_frame(hi2, lo2);
        expect_true(hi * 100 + lo != hi2 * 100 + lo2, "stopwatch did not restart after clear");

        $display("closing: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/clock_pkg.sv ====
`default_nettype none

package clock_pkg;

    typedef logic [6:0] cs_t;
    typedef logic [5:0] sec_t;
    typedef logic [5:0] min_t;
    typedef logic [4:0] hour_t;
    typedef logic [3:0] digit_t;
    typedef logic [7:0] seg_t;    // active low, dp in bit 7

    localparam int unsigned CS_MOD   = 100;
    localparam int unsigned SEC_MOD  = 60;
    localparam int unsigned MIN_MOD  = 60;
    localparam int unsigned HOUR_MOD = 24;

    localparam hour_t HOUR_RESET       = 5'd12;
    localparam hour_t CUCKOO_FROM_HOUR = 5'd7;
    localparam cs_t   DP_FROM_CS       = 7'd50;

    // digits 0..9
    localparam seg_t SEG_DIGITS [10] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,
        8'h92, 8'h82, 8'hf8, 8'h80, 8'h90
    };
    localparam seg_t SEG_DP    = 8'h7f;
    localparam seg_t SEG_BLANK = 8'hff;

    // 100 MHz board clock
    localparam int unsigned CS_TICKS_DEFAULT   = 1_000_000;
    localparam int unsigned SCAN_TICKS_DEFAULT = 100_000;

endpackage

`default_nettype wire

// ==== logic/digital_clock_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module digital_clock_top #(
    parameter int unsigned CS_TICKS   = clock_pkg::CS_TICKS_DEFAULT,
    parameter int unsigned SCAN_TICKS = clock_pkg::SCAN_TICKS_DEFAULT
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_btn_up,
    input  wire              i_btn_down,
    input  wire              i_btn_run_stop,
    input  wire              i_btn_clear,
    input  wire              i_sel_stopwatch,
    input  wire              i_show_hour_min,
    input  wire              i_set_sec,
    input  wire              i_set_min,
    input  wire              i_set_hour,
    output clock_pkg::seg_t  o_fnd_data,
    output logic [3:0]       o_fnd_com,
    output logic             o_cuckoo
);
    time_if watch_t ();
    time_if stop_t ();

    watch_core #(.CS_TICKS(CS_TICKS)) u_watch (
        .clk             (clk),
        .rst             (rst),
        .i_sel_stopwatch (i_sel_stopwatch),
        .i_set_sec       (i_set_sec),
        .i_set_min       (i_set_min),
        .i_set_hour      (i_set_hour),
        .i_btn_up        (i_btn_up),
        .i_btn_down      (i_btn_down),
        .o_time          (watch_t),
        .o_cuckoo        (o_cuckoo)
    );

    stopwatch_core #(.CS_TICKS(CS_TICKS)) u_stopwatch (
        .clk             (clk),
        .rst             (rst),
        .i_sel_stopwatch (i_sel_stopwatch),
        .i_btn_run_stop  (i_btn_run_stop),
        .i_btn_clear     (i_btn_clear),
        .o_time          (stop_t)
    );

    fnd_scan #(.SCAN_TICKS(SCAN_TICKS)) u_fnd (
        .clk             (clk),
        .rst             (rst),
        .i_sel_stopwatch (i_sel_stopwatch),
        .i_show_hour_min (i_show_hour_min),
        .i_watch         (watch_t),
        .i_stop          (stop_t),
        .o_fnd_data      (o_fnd_data),
        .o_fnd_com       (o_fnd_com)
    );

endmodule

`default_nettype wire

// ==== logic/fnd_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module fnd_scan #(
    parameter int unsigned SCAN_TICKS = clock_pkg::SCAN_TICKS_DEFAULT
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_sel_stopwatch,
    input  wire              i_show_hour_min,
    time_if.consumer         i_watch,
    time_if.consumer         i_stop,
    output clock_pkg::seg_t  o_fnd_data,
    output logic [3:0]       o_fnd_com
);
    logic                   scan_tick;
    logic [2:0]             phase;
    clock_pkg::cs_t         cs_src;
    clock_pkg::sec_t        sec_src;
    clock_pkg::min_t        min_src;
    clock_pkg::hour_t       hour_src;
    logic [6:0]             lo_field;     // min or cs
    logic [5:0]             hi_field;     // hour or sec
    clock_pkg::digit_t      lo_ones;
    clock_pkg::digit_t      lo_tens;
    clock_pkg::digit_t      hi_ones;
    clock_pkg::digit_t      hi_tens;
    logic                   dp_on;

    function automatic clock_pkg::seg_t seg_of(input clock_pkg::digit_t d);
        if (d <= 4'd9) begin
            return clock_pkg::SEG_DIGITS[d];
        end
        return clock_pkg::SEG_BLANK;
    endfunction

    tick_divider #(.PERIOD(SCAN_TICKS)) u_scan_div (
        .clk      (clk),
        .rst      (rst),
        .i_enable (1'b1),
        .i_clear  (1'b0),
        .o_tick   (scan_tick)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= 3'd0;
        end else if (scan_tick) begin
            phase <= phase + 3'd1;
        end
    end

    // source select
    assign cs_src   = i_sel_stopwatch ? i_stop.cs   : i_watch.cs;
    assign sec_src  = i_sel_stopwatch ? i_stop.sec  : i_watch.sec;
    assign min_src  = i_sel_stopwatch ? i_stop.min  : i_watch.min;
    assign hour_src = i_sel_stopwatch ? i_stop.hour : i_watch.hour;

    assign lo_field = i_show_hour_min ? {1'b0, min_src} : cs_src;
    assign hi_field = i_show_hour_min ? {1'b0, hour_src} : sec_src;

    assign lo_ones = clock_pkg::digit_t'(lo_field % 7'd10);
    assign lo_tens = clock_pkg::digit_t'(lo_field / 7'd10);
    assign hi_ones = clock_pkg::digit_t'(hi_field % 6'd10);
    assign hi_tens = clock_pkg::digit_t'(hi_field / 6'd10);

    // second half of each second
    assign dp_on = (cs_src >= clock_pkg::DP_FROM_CS);

    assign o_fnd_com = ~(4'b0001 << phase[1:0]);

    always_comb begin
        case (phase)
            3'd0:    o_fnd_data = seg_of(lo_ones);
            3'd1:    o_fnd_data = seg_of(lo_tens);
            3'd2:    o_fnd_data = seg_of(hi_ones);
            3'd3:    o_fnd_data = seg_of(hi_tens);
            3'd6:    o_fnd_data = dp_on ? clock_pkg::SEG_DP : clock_pkg::SEG_BLANK;
            default: o_fnd_data = clock_pkg::SEG_BLANK;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/stopwatch_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module stopwatch_core #(
    parameter int unsigned CS_TICKS = clock_pkg::CS_TICKS_DEFAULT
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       i_sel_stopwatch,
    input  wire       i_btn_run_stop,
    input  wire       i_btn_clear,
    time_if.producer  o_time
);
    typedef enum logic [1:0] {
        STOP  = 2'd0,
        RUN   = 2'd1,
        CLEAR = 2'd2
    } sw_state_t;

    sw_state_t        state;
    sw_state_t        state_next;
    logic             run_stop;
    logic             clear_btn;
    logic             running;
    logic             clearing;
    logic             cs_tick;
    logic             cs_carry;
    logic             sec_carry;
    logic             min_carry;

    // buttons only count while the stopwatch is shown
    assign run_stop  = i_btn_run_stop & i_sel_stopwatch;
    assign clear_btn = i_btn_clear & i_sel_stopwatch;

    always_comb begin
        state_next = state;
        case (state)
            STOP: begin
                if (clear_btn) begin
                    state_next = CLEAR;
                end else if (run_stop) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (run_stop) begin
                    state_next = STOP;
                end
            end
            CLEAR: begin
                if (clear_btn) begin
                    state_next = STOP;
                end
            end
            default: state_next = STOP;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= STOP;
        end else begin
            state <= state_next;
        end
    end

    assign running  = (state == RUN);
    assign clearing = (state == CLEAR);

    tick_divider #(.PERIOD(CS_TICKS)) u_cs_div (
        .clk      (clk),
        .rst      (rst),
        .i_enable (running),
        .i_clear  (clearing),
        .o_tick   (cs_tick)
    );

    time_counter #(.MODULUS(clock_pkg::CS_MOD)) u_cs (
        .clk     (clk),
        .rst     (rst),
        .i_up    (cs_tick),
        .i_down  (1'b0),
        .i_clear (clearing),
        .o_value (o_time.cs),
        .o_carry (cs_carry)
    );

    time_counter #(.MODULUS(clock_pkg::SEC_MOD)) u_sec (
        .clk     (clk),
        .rst     (rst),
        .i_up    (cs_carry),
        .i_down  (1'b0),
        .i_clear (clearing),
        .o_value (o_time.sec),
        .o_carry (sec_carry)
    );

    time_counter #(.MODULUS(clock_pkg::MIN_MOD)) u_min (
        .clk     (clk),
        .rst     (rst),
        .i_up    (sec_carry),
        .i_down  (1'b0),
        .i_clear (clearing),
        .o_value (o_time.min),
        .o_carry (min_carry)
    );

    time_counter #(.MODULUS(clock_pkg::HOUR_MOD)) u_hour (
        .clk     (clk),
        .rst     (rst),
        .i_up    (min_carry),
        .i_down  (1'b0),
        .i_clear (clearing),
        .o_value (o_time.hour),
        .o_carry ()
    );

endmodule

`default_nettype wire

// ==== logic/tick_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

module tick_divider #(
    parameter int unsigned PERIOD = 4
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  i_enable,
    input  wire  i_clear,
    output logic o_tick
);
    localparam int unsigned CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (i_clear) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (i_enable) begin
            if (count == CNT_W'(PERIOD - 1)) begin
                count  <= '0;
                o_tick <= 1'b1;
            end else begin
                count  <= count + 1'b1;
                o_tick <= 1'b0;
            end
        end else begin
            o_tick <= 1'b0;    // hold count while paused
        end
    end

endmodule

`default_nettype wire

// ==== logic/time_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module time_counter #(
    parameter int unsigned MODULUS     = 60,
    parameter int unsigned RESET_VALUE = 0
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_up,
    input  wire                         i_down,
    input  wire                         i_clear,
    output logic [$clog2(MODULUS)-1:0]  o_value,
    output logic                        o_carry
);
    localparam int unsigned W = $clog2(MODULUS);

    logic [W-1:0] value_next;
    logic         carry_next;

    always_comb begin
        value_next = o_value;
        carry_next = 1'b0;
        if (i_clear) begin
            value_next = '0;
        end else if (i_down) begin
            // down wins over up, no borrow out
            if (o_value == '0) begin
                value_next = W'(MODULUS - 1);
            end else begin
                value_next = o_value - 1'b1;
            end
        end else if (i_up) begin
            if (o_value == W'(MODULUS - 1)) begin
                value_next = '0;
                carry_next = 1'b1;
            end else begin
                value_next = o_value + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_value <= W'(RESET_VALUE);
            o_carry <= 1'b0;
        end else begin
            o_value <= value_next;
            o_carry <= carry_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/time_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one timekeeper's fields, registered levels
interface time_if;

    clock_pkg::cs_t   cs;
    clock_pkg::sec_t  sec;
    clock_pkg::min_t  min;
    clock_pkg::hour_t hour;

    modport producer (
        output cs, sec, min, hour
    );

    modport consumer (
        input cs, sec, min, hour
    );

endinterface

`default_nettype wire

// ==== logic/watch_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module watch_core #(
    parameter int unsigned CS_TICKS = clock_pkg::CS_TICKS_DEFAULT
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       i_sel_stopwatch,
    input  wire       i_set_sec,
    input  wire       i_set_min,
    input  wire       i_set_hour,
    input  wire       i_btn_up,
    input  wire       i_btn_down,
    time_if.producer  o_time,
    output logic      o_cuckoo
);
    logic                   cs_tick;
    logic                   set_mode;
    logic [2:0]             field_sel;    // {hour, min, sec}
    logic [1:0]             btn_prev;     // {down, up}
    logic [1:0]             btn_rise;
    logic [2:0]             up_step;
    logic [2:0]             dn_step;
    logic                   cs_carry;
    logic                   sec_carry;
    logic                   min_carry;
    clock_pkg::cs_t         cs_q;
    clock_pkg::sec_t        sec_q;
    clock_pkg::min_t        min_q;
    clock_pkg::hour_t       hour_q;

    // sec over min over hour
    always_comb begin
        if (i_set_sec) begin
            field_sel = 3'b001;
        end else if (i_set_min) begin
            field_sel = 3'b010;
        end else if (i_set_hour) begin
            field_sel = 3'b100;
        end else begin
            field_sel = 3'b000;
        end
    end

    assign set_mode = !i_sel_stopwatch && (field_sel != 3'b000);
    assign btn_rise = {i_btn_down, i_btn_up} & ~btn_prev;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_prev <= 2'b00;
            up_step  <= 3'b000;
            dn_step  <= 3'b000;
        end else if (set_mode) begin
            btn_prev <= {i_btn_down, i_btn_up};
            up_step  <= field_sel & {3{btn_rise[0]}};
            dn_step  <= field_sel & {3{btn_rise[1]}};
        end else begin
            btn_prev <= 2'b00;
            up_step  <= 3'b000;
            dn_step  <= 3'b000;
        end
    end

    tick_divider #(.PERIOD(CS_TICKS)) u_cs_div (
        .clk      (clk),
        .rst      (rst),
        .i_enable (1'b1),
        .i_clear  (1'b0),
        .o_tick   (cs_tick)
    );

    time_counter #(.MODULUS(clock_pkg::CS_MOD)) u_cs (
        .clk     (clk),
        .rst     (rst),
        .i_up    (cs_tick),
        .i_down  (1'b0),
        .i_clear (1'b0),
        .o_value (cs_q),
        .o_carry (cs_carry)
    );

    time_counter #(.MODULUS(clock_pkg::SEC_MOD)) u_sec (
        .clk     (clk),
        .rst     (rst),
        .i_up    (cs_carry | up_step[0]),
        .i_down  (dn_step[0]),
        .i_clear (1'b0),
        .o_value (sec_q),
        .o_carry (sec_carry)
    );

    time_counter #(.MODULUS(clock_pkg::MIN_MOD)) u_min (
        .clk     (clk),
        .rst     (rst),
        .i_up    (sec_carry | up_step[1]),
        .i_down  (dn_step[1]),
        .i_clear (1'b0),
        .o_value (min_q),
        .o_carry (min_carry)
    );

    time_counter #(
        .MODULUS     (clock_pkg::HOUR_MOD),
        .RESET_VALUE (clock_pkg::HOUR_RESET)
    ) u_hour (
        .clk     (clk),
        .rst     (rst),
        .i_up    (min_carry | up_step[2]),
        .i_down  (dn_step[2]),
        .i_clear (1'b0),
        .o_value (hour_q),
        .o_carry ()               // day rollover unused
    );

    assign o_time.cs   = cs_q;
    assign o_time.sec  = sec_q;
    assign o_time.min  = min_q;
    assign o_time.hour = hour_q;

    // chime on the hour from 7 on
    assign o_cuckoo = (min_q == '0) && (hour_q >= clock_pkg::CUCKOO_FROM_HOUR);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+dv
logic/clock_pkg.sv
logic/time_if.sv
logic/tick_divider.sv
logic/time_counter.sv
logic/watch_core.sv
logic/stopwatch_core.sv
logic/fnd_scan.sv
logic/digital_clock_top.sv
dv/digital_clock_tb.sv
